//--- hdl/fir_coef_regs.sv
//--------------------
// FIR register file
// Eight coefficient registers and the output
// configuration, loaded by a one-cycle write strobe
//--------------------

`timescale 1ns/1ps

module fir_coef_regs
(
    input  logic              clk,
    input  logic              rst_n,
    input  fir_pkg::reg_wr_t  reg_wr,
    output fir_pkg::coef_t    coef [fir_pkg::NUM_TAPS],
    output fir_pkg::out_cfg_t out_cfg
);

    import fir_pkg::*;

    //--------------------
    // Coefficient registers
    //--------------------

    // One register per tap, matched on the full address
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < NUM_TAPS; k++)
            begin
                coef[k] <= '0;
            end
        end
        else if (reg_wr.en)
        begin
            for (int k = 0; k < NUM_TAPS; k++)
            begin
                if (reg_wr.addr == ADDR_W'(k))
                begin
                    coef[k] <= coef_t'(reg_wr.data);
                end
            end
        end
    end

    //--------------------
    // Output configuration
    //--------------------

    // Data bit 3 is sat, bits 2..0 the shift select
    // Addresses 9..15 fall through untouched
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_cfg <= '0;
        end
        else if (reg_wr.en && (reg_wr.addr == ADDR_CFG))
        begin
            out_cfg <= out_cfg_t'(reg_wr.data[$bits(out_cfg_t)-1:0]);
        end
    end

endmodule

//--- hdl/fir_delay_line.sv
//--------------------
// FIR delay line
// Shifts samples in on each strobe and presents
// all tap samples in parallel
//--------------------

`timescale 1ns/1ps

module fir_delay_line
(
    input  logic             clk,
    input  logic             rst_n,
    input  fir_pkg::sample_t sample_in,
    input  logic             sample_valid,
    output fir_pkg::sample_t taps [fir_pkg::NUM_TAPS],
    output logic             taps_valid
);

    import fir_pkg::*;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < NUM_TAPS; k++)
            begin
                taps[k] <= '0;
            end
            taps_valid <= 1'b0;
        end
        else
        begin
            // Strobe follows the data by one cycle
            taps_valid <= sample_valid;

            // Newest sample at position 0, oldest falls off the end
            if (sample_valid)
            begin
                taps[0] <= sample_in;
                for (int k = 1; k < NUM_TAPS; k++)
                begin
                    taps[k] <= taps[k-1];
                end
            end
        end
    end

endmodule

//--- hdl/fir_filter_top.sv
//--------------------
// FIR filter top level
// Eight-tap filter: register file, delay line,
// tap array, adder and output stage
//--------------------

`timescale 1ns/1ps

module fir_filter_top
(
    input  logic             clk,
    input  logic             rst_n,
    input  fir_pkg::reg_wr_t reg_wr,
    input  fir_pkg::sample_t sample_in,
    input  logic             sample_valid,
    input  logic             flag_clear,
    output fir_pkg::sample_t filter_out,
    output logic             result_valid,
    output logic             ovf_flag
);

    import fir_pkg::*;

    coef_t    coef [NUM_TAPS];
    out_cfg_t out_cfg;
    sample_t  taps [NUM_TAPS];
    logic     taps_valid;
    prod_t    prods [NUM_TAPS];
    logic     prods_valid;
    acc_t     acc;
    logic     acc_valid;

    fir_coef_regs u_coef_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_wr  (reg_wr),
        .coef    (coef),
        .out_cfg (out_cfg)
    );

    // Sample captured at E, taps valid after E
    fir_delay_line u_delay_line (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .taps         (taps),
        .taps_valid   (taps_valid)
    );

    //--------------------
    // Tap array
    //--------------------

    // Products at E+1
    for (genvar k = 0; k < NUM_TAPS; k++)
    begin : g_tap
        fir_tap u_tap (
            .clk    (clk),
            .rst_n  (rst_n),
            .sample (taps[k]),
            .coef   (coef[k]),
            .prod   (prods[k])
        );
    end

    // Strobe stage matching the tap register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prods_valid <= 1'b0;
        end
        else
        begin
            prods_valid <= taps_valid;
        end
    end

    // Accumulator at E+2
    fir_sum u_sum (
        .clk         (clk),
        .rst_n       (rst_n),
        .prods       (prods),
        .prods_valid (prods_valid),
        .acc         (acc),
        .acc_valid   (acc_valid)
    );

    // Three more stages, result at E+5
    fir_round_truncate u_round_truncate (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_in       (acc),
        .acc_valid    (acc_valid),
        .out_cfg      (out_cfg),
        .flag_clear   (flag_clear),
        .filter_out   (filter_out),
        .result_valid (result_valid),
        .ovf_flag     (ovf_flag)
    );

endmodule

//--- hdl/fir_pkg.sv
//--------------------
// FIR filter package
// Widths, tap count, shift range, register map
// and the structs shared by the filter blocks
//--------------------

package fir_pkg;

    // Widths and counts
    localparam int NUM_TAPS    = 8;
    localparam int SAMPLE_W    = 16;
    localparam int COEF_W      = 16;
    localparam int PROD_W      = 32;
    localparam int ACC_W       = 40;
    localparam int OUT_W       = 16;

    // Output shift runs from SHIFT_BASE to SHIFT_BASE + 7
    localparam int SHIFT_BASE  = 12;
    localparam int SHIFT_SEL_W = 3;
    localparam int SHIFT_W     = 5;

    // Rounding headroom: 8 guard bits + 16 kept + up to 19 dropped
    localparam int RND_W       = ACC_W + 3;
    localparam int TRUNC_W     = 24;

    // Register map, addresses 0..7 are the coefficients
    localparam int ADDR_W      = 4;
    localparam logic [ADDR_W-1:0] ADDR_CFG = 4'd8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // Clip limits of the output word
    localparam sample_t OUT_MAX = 16'sh7FFF;
    localparam sample_t OUT_MIN = 16'sh8000;

    // Output config, sat high clips and low wraps
    typedef struct packed {
        logic                   sat;
        logic [SHIFT_SEL_W-1:0] shift_sel;
    } out_cfg_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [COEF_W-1:0] data;
    } reg_wr_t;

endpackage

//--- hdl/fir_round_truncate.sv
//--------------------
// FIR output stage
// Rounds and shifts the accumulator, then clips or
// wraps to 16 bits and keeps a sticky overflow flag
//--------------------

`timescale 1ns/1ps

module fir_round_truncate
(
    input  logic              clk,
    input  logic              rst_n,
    input  fir_pkg::acc_t     acc_in,
    input  logic              acc_valid,
    input  fir_pkg::out_cfg_t out_cfg,
    input  logic              flag_clear,
    output fir_pkg::sample_t  filter_out,
    output logic              result_valid,
    output logic              ovf_flag
);

    import fir_pkg::*;

    logic [SHIFT_W-1:0]      num_shift;
    logic signed [RND_W-1:0] ext_acc;
    logic signed [RND_W-1:0] half_lsb;
    logic signed [RND_W-1:0] acc_r;
    logic signed [TRUNC_W-1:0] acc_t;
    logic                    rnd_valid;
    logic                    trunc_valid;
    logic                    out_of_range;

    // Shift of 12..19 from the 3-bit select
    assign num_shift = SHIFT_W'(SHIFT_BASE) + SHIFT_W'(out_cfg.shift_sel);

    // Three guard bits on top so the rounding add cannot overflow
    assign ext_acc  = {{(RND_W-ACC_W){acc_in[ACC_W-1]}}, acc_in};
    assign half_lsb = RND_W'(1) << (num_shift - 1'b1);

    // In range when the top bits above the output width all agree
    assign out_of_range = !((&acc_t[TRUNC_W-1:OUT_W-1]) || !(|acc_t[TRUNC_W-1:OUT_W-1]));

    //--------------------
    // Round and shift
    //--------------------

    // acc_r at E+3, acc_t at E+4
    // Shift 12 keeps bits 35..12, shift 19 keeps 42..19
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc_r       <= '0;
            acc_t       <= '0;
            rnd_valid   <= 1'b0;
            trunc_valid <= 1'b0;
        end
        else
        begin
            acc_r       <= ext_acc + half_lsb;
            acc_t       <= acc_r[num_shift +: TRUNC_W];
            rnd_valid   <= acc_valid;
            trunc_valid <= rnd_valid;
        end
    end

    //--------------------
    // Clip or wrap, flag
    //--------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            filter_out   <= '0;
            result_valid <= 1'b0;
            ovf_flag     <= 1'b0;
        end
        else
        begin
            result_valid <= trunc_valid;

            // Output holds its value between results
            if (trunc_valid)
            begin
                if (out_of_range && out_cfg.sat)
                begin
                    filter_out <= acc_t[TRUNC_W-1] ? OUT_MIN : OUT_MAX;
                end
                else
                begin
                    // Low 16 bits, wraps when out of range
                    filter_out <= sample_t'(acc_t[OUT_W-1:0]);
                end
            end

            // A clear beats an overflow in the same cycle
            if (flag_clear)
            begin
                ovf_flag <= 1'b0;
            end
            else if (trunc_valid && out_of_range)
            begin
                ovf_flag <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/fir_sum.sv
//--------------------
// FIR product adder
// Sign-extends all tap products and registers
// their sum as the accumulator
//--------------------

`timescale 1ns/1ps

module fir_sum
(
    input  logic           clk,
    input  logic           rst_n,
    input  fir_pkg::prod_t prods [fir_pkg::NUM_TAPS],
    input  logic           prods_valid,
    output fir_pkg::acc_t  acc,
    output logic           acc_valid
);

    import fir_pkg::*;

    acc_t sum_c;

    // Eight guard bits, no overflow possible for eight taps
    always_comb
    begin
        sum_c = '0;
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            sum_c = sum_c + acc_t'({{(ACC_W-PROD_W){prods[k][PROD_W-1]}}, prods[k]});
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end
        else
        begin
            acc       <= sum_c;
            // Strobe stays aligned with the sum
            acc_valid <= prods_valid;
        end
    end

endmodule

//--- hdl/fir_tap.sv
//--------------------
// FIR tap multiplier
// Registered signed sample times coefficient
//--------------------

`timescale 1ns/1ps

module fir_tap
(
    input  logic             clk,
    input  logic             rst_n,
    input  fir_pkg::sample_t sample,
    input  fir_pkg::coef_t   coef,
    output fir_pkg::prod_t   prod
);

    import fir_pkg::*;

    prod_t prod_c;

    // Both operands signed, 16x16 always fits in 32 bits
    always_comb
    begin
        prod_c = sample * coef;
    end

    // Free running, the strobe is tracked in the top level
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prod <= '0;
        end
        else
        begin
            prod <= prod_c;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIR filter testbench with Verilator
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module fir_filter_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vfir_filter_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
else
    exit 1
fi

//--- src.f
hdl/fir_pkg.sv
hdl/fir_coef_regs.sv
hdl/fir_delay_line.sv
hdl/fir_tap.sv
hdl/fir_sum.sv
hdl/fir_round_truncate.sv
hdl/fir_filter_top.sv
tests/fir_filter_tb.sv

//--- tests/fir_filter_tb.sv
//--------------------
// FIR filter testbench
// Replays write, sample, clear and expect commands
// from the data file and checks every result
//--------------------

`timescale 1ns/1ps

module fir_filter_tb;

    import fir_pkg::*;

    localparam int    CLK_PERIOD  = 8;
    localparam int    RESET_CYC   = 4;
    localparam int    LATENCY     = 5;
    localparam int    DRAIN_LIMIT = 20;
    localparam int    LINE_CYC    = 20;
    localparam string DATA_FILE   = "tests/fir_testdata.txt";

    // Expected output word and flag for one result
    typedef struct packed {
        sample_t value;
        logic    ovf;
    } expect_t;

    logic    clk;
    logic    rst_n;
    reg_wr_t reg_wr;
    sample_t sample_in;
    logic    sample_valid;
    logic    flag_clear;
    sample_t filter_out;
    logic    result_valid;
    logic    ovf_flag;

    expect_t exp_q [$];
    int      cap_q [$];
    int      cyc;
    int      n_lines;
    int      test_num;
    int      test_checks;
    int      test_errors;
    int      total_checks;
    int      total_errors;
    int      num_tests;

    fir_filter_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .flag_clear   (flag_clear),
        .filter_out   (filter_out),
        .result_valid (result_valid),
        .ovf_flag     (ovf_flag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Edge counter, used to measure latency
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    //--------------------
    // Result checker
    //--------------------

    // Outputs change on the edge, so the previous values are read here
    always @(posedge clk)
    begin
        expect_t e;
        int      cap;
        if (rst_n && result_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR at %0t: result_valid high with no result expected", $time);
                test_errors++;
            end
            else
            begin
                e   = exp_q.pop_front();
                cap = (cap_q.size() > 0) ? cap_q.pop_front() : -1;
                test_checks++;
                assert (filter_out === e.value)
                else
                begin
                    $display("FAILED t=%0t filter_out got %0d expected %0d",
                             $time, filter_out, e.value);
                    test_errors++;
                end
                assert (ovf_flag === e.ovf)
                else
                begin
                    $display("FAILED t=%0t ovf_flag got %0b expected %0b",
                             $time, ovf_flag, e.ovf);
                    test_errors++;
                end
                // Result was written one edge before this one
                assert ((cyc - 1) - cap == LATENCY)
                else
                begin
                    $display("FAILED t=%0t latency got %0d expected %0d",
                             $time, (cyc - 1) - cap, LATENCY);
                    test_errors++;
                end
            end
        end
    end

    //--------------------
    // Stimulus tasks
    //--------------------

    task automatic release_strobes();
        @(posedge clk);
        sample_valid <= 1'b0;
        flag_clear   <= 1'b0;
        reg_wr.en    <= 1'b0;
    endtask

    // Wait until every expected result has arrived
    task automatic drain();
        int waited;
        waited = 0;
        release_strobes();
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0)
        begin
            $display("ERROR at %0t: test %0d, result_valid never came for %0d results",
                     $time, test_num, exp_q.size());
            test_errors += exp_q.size();
            exp_q.delete();
            cap_q.delete();
        end
    endtask

    task automatic finish_test();
        drain();
        $display("test %0d: %0d checks, %0d errors, %s", test_num, test_checks,
                 test_errors, (test_errors == 0) ? "ok" : "failed");
        total_checks += test_checks;
        total_errors += test_errors;
        num_tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Writes and clears only go out with the pipeline idle
    task automatic write_reg(input int addr, input int data);
        drain();
        @(posedge clk);
        reg_wr <= '{en: 1'b1, addr: ADDR_W'(addr), data: COEF_W'(data)};
        release_strobes();
    endtask

    task automatic clear_flag();
        drain();
        @(posedge clk);
        flag_clear <= 1'b1;
        release_strobes();
    endtask

    // DUT captures at the next edge
    task automatic drive_sample(input int value);
        @(posedge clk);
        sample_in    <= sample_t'(value);
        sample_valid <= 1'b1;
        cap_q.push_back(cyc + 1);
    endtask

    //--------------------
    // Main sequence
    //--------------------

    initial
    begin
        int          fd;
        string       line;
        int          tn;
        logic [7:0]  cmd;
        int          a;
        int          b;
        expect_t     e_new;
        clk          = 1'b0;
        rst_n        = 1'b0;
        reg_wr       = '0;
        sample_in    = '0;
        sample_valid = 1'b0;
        flag_clear   = 1'b0;
        cyc          = 0;
        n_lines      = 0;
        test_num     = -1;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        num_tests    = 0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the test data file %s", DATA_FILE);
            total_errors = 1;
        end
        else
        begin
            // First pass only counts lines for the watchdog
            while ($fgets(line, fd))
            begin
                n_lines++;
            end
            $fclose(fd);
            fd = $fopen(DATA_FILE, "r");

            repeat (RESET_CYC) @(posedge clk);
            rst_n <= 1'b1;

            // Comment and blank lines fail the scan and are skipped
            while ($fgets(line, fd))
            begin
                if ($sscanf(line, "%d %c %d %d", tn, cmd, a, b) == 4)
                begin
                    if (tn != test_num)
                    begin
                        if (test_num >= 0)
                        begin
                            finish_test();
                        end
                        test_num = tn;
                    end
                    case (cmd)
                        "W": write_reg(a, b);
                        "S": drive_sample(a);
                        "C": clear_flag();
                        "E":
                        begin
                            e_new.value = sample_t'(a);
                            e_new.ovf   = b[0];
                            exp_q.push_back(e_new);
                        end
                        default:
                        begin
                            $display("ERROR: unknown command %c in test %0d", cmd, tn);
                            test_errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (test_num >= 0)
            begin
                finish_test();
            end
        end

        $display("total: %0d tests, %0d checks, %0d errors",
                 num_tests, total_checks, total_errors);
        if (total_errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog scaled to the length of the data file
    initial
    begin
        wait (n_lines > 0);
        repeat (n_lines * LINE_CYC) @(posedge clk);
        $display("ERROR: watchdog timeout, the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tests/fir_testdata.txt
# test cmd arg1 arg2: W addr data, S sample 0, C 0 0, E filter_out ovf_flag
# E lines come ahead of the S lines whose results they predict
1 W 8 0
1 W 0 100
1 W 1 -200
1 W 2 300
1 W 3 -400
1 W 4 500
1 W 5 -600
1 W 6 700
1 W 7 -800
1 E 100 0
1 E -200 0
1 E 300 0
1 E -400 0
1 E 500 0
1 E -600 0
1 E 700 0
1 E -800 0
1 S 4096 0
1 S 0 0
1 S 0 0
1 S 0 0
1 S 0 0
1 S 0 0
1 S 0 0
1 S 0 0
2 W 1 0
2 W 2 0
2 W 3 0
2 W 4 0
2 W 5 0
2 W 6 0
2 W 7 0
2 W 0 1
2 E 1 0
2 S 2048 0
2 W 8 7
2 W 0 16
2 E 1 0
2 S 16384 0
3 W 0 32767
3 W 8 8
3 E 32767 1
3 S 32767 0
3 E -32768 1
3 S -32768 0
4 C 0 0
4 W 8 0
4 E -16 1
4 S 32767 0
4 E 8 1
4 S -32768 0
5 E 8 1
5 S 1 0
5 C 0 0
5 E 8 0
5 S 1 0
6 W 0 4096
6 E 10 0
6 E -20 0
6 E 30 0
6 E -40 0
6 S 10 0
6 S -20 0
6 S 30 0
6 S -40 0
